//--- hw/fxPkg.sv
`default_nettype none

package fxPkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////
	localparam int GPR_W = 64; // Architected GPR width
	localparam int NUM_GPR = 32; // GPR count
	localparam int REG_AW = 5; // Register number width
	localparam int IMM_W = 16; // D-form SI/UI field
	localparam int CR_W = 32; // Eight 4-bit CR fields
	localparam int INSTR_W = 32; // Instruction word
	localparam int APB_DW = 32; // APB data bus

	// Big-endian numbering, bit 0 is the MSB
	typedef logic [0:GPR_W-1] gprT;
	typedef logic [0:REG_AW-1] regAddrT;
	typedef logic [0:IMM_W-1] immT;
	typedef logic [0:CR_W-1] crT; // Field 0 leftmost, LT GT EQ SO
	typedef logic [0:INSTR_W-1] instrT;
	typedef logic [APB_DW-1:0] apbDataT; // Bus side keeps the usual order

	typedef enum logic [3:0] {
		opAddi,
		opAddis,
		opAddic,
		opAddicRc,
		opSubfic,
		opMulli,
		opAndi, // Record form only
		opAndis, // Record form only
		opOri,
		opOris,
		opXori,
		opXoris,
		opCmpi,
		opCmpli
	} fxOpT;

	////////////////////////////////////////
	// Primary opcodes, bits 0-5
	////////////////////////////////////////
	localparam logic [5:0] OPC_MULLI = 6'd7;
	localparam logic [5:0] OPC_SUBFIC = 6'd8;
	localparam logic [5:0] OPC_CMPLI = 6'd10;
	localparam logic [5:0] OPC_CMPI = 6'd11;
	localparam logic [5:0] OPC_ADDIC = 6'd12;
	localparam logic [5:0] OPC_ADDICRC = 6'd13;
	localparam logic [5:0] OPC_ADDI = 6'd14;
	localparam logic [5:0] OPC_ADDIS = 6'd15;
	localparam logic [5:0] OPC_ORI = 6'd24;
	localparam logic [5:0] OPC_ORIS = 6'd25;
	localparam logic [5:0] OPC_XORI = 6'd26;
	localparam logic [5:0] OPC_XORIS = 6'd27;
	localparam logic [5:0] OPC_ANDI = 6'd28;
	localparam logic [5:0] OPC_ANDIS = 6'd29;

	////////////////////////////////////////
	// APB register offsets
	////////////////////////////////////////
	localparam int unsigned ADDR_INSTR = 32'h000; // Write issues
	localparam int unsigned ADDR_CR = 32'h004; // Read only
	localparam int unsigned ADDR_XER = 32'h008; // CA in bit 0
	localparam int unsigned ADDR_GPR_BASE = 32'h100; // 8 bytes per GPR

endpackage

`default_nettype wire

//--- hw/fxDecode.sv
`timescale 1ns/1ps
`default_nettype none

module fxDecode (
	input wire fxPkg::instrT instr_i,
	output fxPkg::fxOpT op_o,
	output fxPkg::regAddrT rt_o,
	output fxPkg::regAddrT ra_o,
	output fxPkg::immT imm_o,
	output logic [2:0] bf_o,
	output logic lBit_o,
	output logic illegal_o
);
	import fxPkg::*;

	logic [5:0] primOp; // Primary opcode
	logic logical; // RS in bits 6-10, RA is the target

	assign primOp = instr_i[0:5];
	assign imm_o = instr_i[16:31]; // SI or UI
	assign bf_o = instr_i[6:8]; // Compare target field
	assign lBit_o = instr_i[10]; // 1 selects 64-bit compare

	always_comb begin
		op_o = opAddi; // Don't care when illegal
		illegal_o = 1'b0;
		logical = 1'b0;
		case (primOp)
			OPC_ADDI: op_o = opAddi;
			OPC_ADDIS: op_o = opAddis;
			OPC_ADDIC: op_o = opAddic;
			OPC_ADDICRC: op_o = opAddicRc;
			OPC_SUBFIC: op_o = opSubfic;
			OPC_MULLI: op_o = opMulli;
			OPC_CMPI: op_o = opCmpi;
			OPC_CMPLI: op_o = opCmpli;
			OPC_ORI: begin
				op_o = opOri;
				logical = 1'b1;
			end
			OPC_ORIS: begin
				op_o = opOris;
				logical = 1'b1;
			end
			OPC_XORI: begin
				op_o = opXori;
				logical = 1'b1;
			end
			OPC_XORIS: begin
				op_o = opXoris;
				logical = 1'b1;
			end
			OPC_ANDI: begin
				op_o = opAndi;
				logical = 1'b1;
			end
			OPC_ANDIS: begin
				op_o = opAndis;
				logical = 1'b1;
			end
			default: illegal_o = 1'b1; // Belongs to another unit
		endcase
	end

	// Logical forms swap source and target fields
	assign rt_o = logical ? instr_i[11:15] : instr_i[6:10];
	assign ra_o = logical ? instr_i[6:10] : instr_i[11:15];

endmodule

`default_nettype wire

//--- hw/fxRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module fxRegFile (
	input wire clock_i,
	input wire rstN_i,
	input wire fxPkg::regAddrT rdAddrA_i, // Execution operand
	input wire fxPkg::regAddrT rdAddrB_i, // Host readback
	output fxPkg::gprT rdDataA_o,
	output fxPkg::gprT rdDataB_o,
	input wire we_i,
	input wire fxPkg::regAddrT wrAddr_i,
	input wire fxPkg::gprT wrData_i
);
	import fxPkg::*;

	gprT regs [NUM_GPR]; // GPR0 is a real register

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////
	always_ff @(posedge clock_i or negedge rstN_i) begin
		if (!rstN_i) begin
			for (int i = 0; i < NUM_GPR; i++) begin
				regs[i] <= '0; // Architected state starts at zero
			end
		end else if (we_i) begin
			regs[wrAddr_i] <= wrData_i;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////
	// No bypass, the next access comes two cycles after issue
	assign rdDataA_o = regs[rdAddrA_i];
	assign rdDataB_o = regs[rdAddrB_i];

endmodule

`default_nettype wire

//--- hw/fxUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fxUnit (
	input wire clock_i,
	input wire rstN_i,
	input wire issue_i,
	input wire fxPkg::fxOpT op_i,
	input wire fxPkg::regAddrT rt_i,
	input wire fxPkg::regAddrT ra_i,
	input wire fxPkg::immT imm_i,
	input wire [2:0] bf_i,
	input wire lBit_i,
	input wire fxPkg::gprT raData_i,
	output logic wbValid_o,
	output fxPkg::regAddrT wbAddr_o,
	output fxPkg::gprT wbData_o,
	output fxPkg::crT cr_o,
	output logic ca_o
);
	import fxPkg::*;

	gprT siExt; // SI sign-extended
	gprT siShift; // SI || 0x0000
	gprT uiExt; // UI zero-extended
	gprT uiShift; // UI || 0x0000
	gprT opA; // (RA|0)
	logic [GPR_W:0] addSum; // Carry in MSB
	logic [GPR_W:0] subSum;
	gprT result;
	logic carry;
	logic setsCa;
	logic records;
	logic isCmp;
	gprT cmpA;
	gprT cmpB;
	logic lt;
	logic gt;
	logic eq;
	logic [3:0] cr0;
	crT crNext;

	////////////////////////////////////////
	// Operands
	////////////////////////////////////////
	assign siExt = {{(GPR_W-IMM_W){imm_i[0]}}, imm_i};
	assign siShift = {{(GPR_W-2*IMM_W){imm_i[0]}}, imm_i, {IMM_W{1'b0}}};
	assign uiExt = {{(GPR_W-IMM_W){1'b0}}, imm_i};
	assign uiShift = {{(GPR_W-2*IMM_W){1'b0}}, imm_i, {IMM_W{1'b0}}};
	assign opA = ((ra_i == '0) && (op_i == opAddi || op_i == opAddis)) ? '0 : raData_i;

	assign addSum = {1'b0, opA} + {1'b0, siExt};
	assign subSum = {1'b0, ~opA} + {1'b0, siExt} + (GPR_W+1)'(1); // ~RA + SI + 1

	////////////////////////////////////////
	// Execute
	////////////////////////////////////////
	always_comb begin
		result = '0;
		carry = 1'b0;
		case (op_i)
			opAddi: result = opA + siExt;
			opAddis: result = opA + siShift;
			opAddic, opAddicRc: begin
				result = addSum[GPR_W-1:0];
				carry = addSum[GPR_W];
			end
			opSubfic: begin
				result = subSum[GPR_W-1:0];
				carry = subSum[GPR_W];
			end
			opMulli: result = $signed(opA) * $signed(siExt); // Low 64 bits
			opAndi: result = opA & uiExt;
			opAndis: result = opA & uiShift;
			opOri: result = opA | uiExt;
			opOris: result = opA | uiShift;
			opXori: result = opA ^ uiExt;
			opXoris: result = opA ^ uiShift;
			default: result = '0; // Compares write no GPR
		endcase
	end

	assign setsCa = (op_i == opAddic) || (op_i == opAddicRc) || (op_i == opSubfic);
	assign records = (op_i == opAddicRc) || (op_i == opAndi) || (op_i == opAndis);
	assign isCmp = (op_i == opCmpi) || (op_i == opCmpli);

	// L=0 compares the low word, extended by signedness
	always_comb begin
		if (lBit_i) begin
			cmpA = raData_i;
		end else if (op_i == opCmpi) begin
			cmpA = {{32{raData_i[32]}}, raData_i[32:63]};
		end else begin
			cmpA = {32'b0, raData_i[32:63]};
		end
		cmpB = (op_i == opCmpi) ? siExt : uiExt;
	end

	assign lt = (op_i == opCmpi) ? ($signed(cmpA) < $signed(cmpB)) : (cmpA < cmpB);
	assign gt = (op_i == opCmpi) ? ($signed(cmpA) > $signed(cmpB)) : (cmpA > cmpB);
	assign eq = cmpA == cmpB;

	// Signed test against zero, SO not modelled
	assign cr0 = {result[0], !result[0] && (result != '0), result == '0, 1'b0};

	always_comb begin
		crNext = cr_o;
		if (records) begin
			crNext[0:3] = cr0;
		end
		if (isCmp) begin
			crNext[{bf_i, 2'b00} +: 4] = {lt, gt, eq, 1'b0}; // Field BF only
		end
	end

	////////////////////////////////////////
	// Architected state and writeback
	////////////////////////////////////////
	always_ff @(posedge clock_i or negedge rstN_i) begin
		if (!rstN_i) begin
			wbValid_o <= 1'b0;
			cr_o <= '0;
			ca_o <= 1'b0;
		end else begin
			wbValid_o <= issue_i && !isCmp; // High for the cycle after E0
			if (issue_i) begin
				cr_o <= crNext;
				if (setsCa) begin
					ca_o <= carry;
				end
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (issue_i) begin
			wbAddr_o <= rt_i;
			wbData_o <= result;
		end
	end

endmodule

`default_nettype wire

//--- hw/fxApbSlave.sv
`timescale 1ns/1ps
`default_nettype none

module fxApbSlave #(
	parameter int ADDR_W = 12 // At least 9 for the GPR window
) (
	input wire clock_i,
	input wire rstN_i,
	input wire [ADDR_W-1:0] paddr_i,
	input wire psel_i,
	input wire penable_i,
	input wire pwrite_i,
	input wire fxPkg::apbDataT pwdata_i,
	output fxPkg::apbDataT prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	input wire illegal_i,
	input wire fxPkg::crT cr_i,
	input wire ca_i,
	input wire fxPkg::gprT hostRdData_i,
	input wire wbValid_i,
	input wire fxPkg::regAddrT wbAddr_i,
	input wire fxPkg::gprT wbData_i,
	output fxPkg::instrT instr_o,
	output logic issue_o,
	output fxPkg::regAddrT hostRdAddr_o,
	output logic rfWe_o,
	output fxPkg::regAddrT rfWrAddr_o,
	output fxPkg::gprT rfWrData_o
);
	import fxPkg::*;

	logic wrAccess; // Access phase write
	logic isInstr;
	logic isCr;
	logic isXer;
	logic isGpr; // 0x100-0x1FF window
	logic hiWord; // Offset +4 in the GPR pair
	logic hostWe;
	apbDataT loStage; // Low half awaiting commit

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////
	assign wrAccess = psel_i && penable_i && pwrite_i;
	assign isInstr = paddr_i == ADDR_W'(ADDR_INSTR);
	assign isCr = paddr_i == ADDR_W'(ADDR_CR);
	assign isXer = paddr_i == ADDR_W'(ADDR_XER);
	assign isGpr = paddr_i[ADDR_W-1:8] == (ADDR_W-8)'(ADDR_GPR_BASE >> 8);
	assign hiWord = paddr_i[2];
	assign hostRdAddr_o = paddr_i[7:3]; // GPR n at base + 8n

	assign pready_o = 1'b1; // No wait states
	assign instr_o = pwdata_i; // Decoder looks at the bus directly
	assign issue_o = wrAccess && isInstr && !illegal_i;
	assign pslverr_o = wrAccess && isInstr && illegal_i; // Rejected, no issue

	////////////////////////////////////////
	// Read mux
	////////////////////////////////////////
	always_comb begin
		prdata_o = '0;
		if (isCr) begin
			prdata_o = cr_i;
		end else if (isXer) begin
			prdata_o = {{(APB_DW-1){1'b0}}, ca_i};
		end else if (isGpr) begin
			prdata_o = hiWord ? hostRdData_i[0:31] : hostRdData_i[32:63];
		end
	end

	////////////////////////////////////////
	// GPR load
	////////////////////////////////////////
	always_ff @(posedge clock_i) begin
		if (wrAccess && isGpr && !hiWord) begin
			loStage <= pwdata_i;
		end
	end

	assign hostWe = wrAccess && isGpr && hiWord; // Commit both halves

	// Unit writeback first, never coincides with an access
	assign rfWe_o = wbValid_i || hostWe;
	assign rfWrAddr_o = wbValid_i ? wbAddr_i : hostRdAddr_o;
	assign rfWrData_o = wbValid_i ? wbData_i : {pwdata_i, loStage};

endmodule

`default_nettype wire

//--- hw/fxTop.sv
`timescale 1ns/1ps
`default_nettype none

module fxTop #(
	parameter int ADDR_W = 12
) (
	input wire clock_i,
	input wire rstN_i,
	input wire [ADDR_W-1:0] paddr_i,
	input wire psel_i,
	input wire penable_i,
	input wire pwrite_i,
	input wire fxPkg::apbDataT pwdata_i,
	output fxPkg::apbDataT prdata_o,
	output logic pready_o,
	output logic pslverr_o
);
	import fxPkg::*;

	instrT instr;
	logic issue;
	logic illegal;
	fxOpT op;
	regAddrT rt;
	regAddrT ra;
	immT imm;
	logic [2:0] bf;
	logic lBit;
	gprT raData; // Port A to the unit
	regAddrT hostRdAddr;
	gprT hostRdData; // Port B to the host
	logic rfWe;
	regAddrT rfWrAddr;
	gprT rfWrData;
	logic wbValid;
	regAddrT wbAddr;
	gprT wbData;
	crT cr;
	logic ca;

	fxApbSlave #(
		.ADDR_W(ADDR_W)
	) apbSlave (
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.paddr_i(paddr_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.illegal_i(illegal),
		.cr_i(cr),
		.ca_i(ca),
		.hostRdData_i(hostRdData),
		.wbValid_i(wbValid),
		.wbAddr_i(wbAddr),
		.wbData_i(wbData),
		.instr_o(instr),
		.issue_o(issue),
		.hostRdAddr_o(hostRdAddr),
		.rfWe_o(rfWe),
		.rfWrAddr_o(rfWrAddr),
		.rfWrData_o(rfWrData)
	);

	fxDecode decode (
		.instr_i(instr),
		.op_o(op),
		.rt_o(rt),
		.ra_o(ra),
		.imm_o(imm),
		.bf_o(bf),
		.lBit_o(lBit),
		.illegal_o(illegal) // Back to the slave for PSLVERR
	);

	fxRegFile regFile (
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.rdAddrA_i(ra),
		.rdAddrB_i(hostRdAddr),
		.rdDataA_o(raData),
		.rdDataB_o(hostRdData),
		.we_i(rfWe),
		.wrAddr_i(rfWrAddr),
		.wrData_i(rfWrData)
	);

	fxUnit unit (
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.issue_i(issue),
		.op_i(op),
		.rt_i(rt),
		.ra_i(ra),
		.imm_i(imm),
		.bf_i(bf),
		.lBit_i(lBit),
		.raData_i(raData),
		.wbValid_o(wbValid),
		.wbAddr_o(wbAddr),
		.wbData_o(wbData),
		.cr_o(cr),
		.ca_o(ca)
	);

endmodule

`default_nettype wire

//--- tb/fxClkGen.sv
`timescale 1ns/1ps
`default_nettype none

module fxClkGen (
	output logic clock_o,
	output logic rstN_o
);

	initial begin
		clock_o = 1'b0;
		forever #5 clock_o = ~clock_o; // 10 ns period
	end

	initial begin
		rstN_o = 1'b0;
		repeat (16) @(posedge clock_o); // Reset held 16 cycles
		rstN_o <= 1'b1;
	end

endmodule

`default_nettype wire

//--- tb/fxApb_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fxApb_chk (
	input wire clock_i,
	input wire rstN_i,
	input wire psel_i,
	input wire penable_i,
	input wire pready_i,
	input wire pslverr_i,
	input wire issue_i,
	input wire illegal_i,
	input wire fxPkg::instrT instr_i,
	input wire wbValid_i
);
	import fxPkg::*;

	logic isCmp; // Compares write no GPR
	logic legalOpc; // Primary opcodes owned by this unit

	assign isCmp = (instr_i[0:5] == OPC_CMPI) || (instr_i[0:5] == OPC_CMPLI);
	assign legalOpc = instr_i[0:5] inside {6'd7, 6'd8, [6'd10:6'd15], [6'd24:6'd29]};

	readyHigh: assert property (@(posedge clock_i) disable iff (!rstN_i) pready_i)
		else $error("pready_o dropped low");

	errInAccess: assert property (@(posedge clock_i) disable iff (!rstN_i)
		pslverr_i |-> (psel_i && penable_i))
		else $error("pslverr_o outside an access cycle");

	wbFollowsIssue: assert property (@(posedge clock_i) disable iff (!rstN_i)
		(issue_i && !isCmp) |=> wbValid_i)
		else $error("No writeback one cycle after issue");

	wbOnlyAfterIssue: assert property (@(posedge clock_i) disable iff (!rstN_i)
		wbValid_i |-> $past(issue_i && !isCmp))
		else $error("Writeback without a matching issue");

	illegalMatches: assert property (@(posedge clock_i) disable iff (!rstN_i)
		illegal_i == !legalOpc)
		else $error("Illegal flag disagrees with the opcode");

	noIssueIllegal: assert property (@(posedge clock_i) disable iff (!rstN_i)
		issue_i |-> legalOpc)
		else $error("Illegal instruction was issued");

endmodule

`default_nettype wire

//--- tb/fxTb.sv
`timescale 1ns/1ps
`default_nettype none

module fxTb;
	import fxPkg::*;

	localparam int ADDR_W = 12;
	localparam int NUM_XFERS = 620; // Upper bound over all tests
	localparam int TIMEOUT_CYCLES = 16 + NUM_XFERS * 4 + 200;

	logic clock;
	logic rstN;
	logic [ADDR_W-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	apbDataT pwdata;
	apbDataT prdata;
	logic pready;
	logic pslverr;

	gprT gprM [32]; // Reference GPRs
	crT crM;
	logic caM;
	logic [31:0] rndState;
	int cycleCount = 0;

	fxClkGen clkGen (
		.clock_o(clock),
		.rstN_o(rstN)
	);

	fxTop #(
		.ADDR_W(ADDR_W)
	) UUT (
		.clock_i(clock),
		.rstN_i(rstN),
		.paddr_i(paddr),
		.psel_i(psel),
		.penable_i(penable),
		.pwrite_i(pwrite),
		.pwdata_i(pwdata),
		.prdata_o(prdata),
		.pready_o(pready),
		.pslverr_o(pslverr)
	);

	bind fxApbSlave fxApb_chk apbChk (
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pready_i(pready_o),
		.pslverr_i(pslverr_o),
		.issue_i(issue_o),
		.illegal_i(illegal_i),
		.instr_i(instr_o),
		.wbValid_i(wbValid_i)
	);

	////////////////////////////////////////
	// Reporting and compares
	////////////////////////////////////////
	task automatic abortRun();
		$display("Something failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkGpr(input string name, input gprT got, input gprT exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkCr(input string name, input crT got, input crT exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
			abortRun();
		end
	endtask

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			abortRun();
		end
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic nextRand(output logic [31:0] r);
		rndState = xorshift32(rndState);
		r = rndState;
	endtask

	function automatic instrT dForm(input logic [5:0] opc, input logic [4:0] f1,
			input logic [4:0] f2, input logic [15:0] imm);
		return {opc, f1, f2, imm};
	endfunction

	function automatic logic [4:0] cmpField(input logic [2:0] bf, input logic l);
		return {bf, 1'b0, l}; // BF, reserved bit, L
	endfunction

	// Setup edge, access edge, sample mid-access, back to idle at completion
	task automatic apbXfer(input logic [ADDR_W-1:0] addr, input logic wr, input apbDataT wdata,
			output apbDataT rdata, output logic err);
		@(posedge clock);
		paddr <= addr;
		pwrite <= wr;
		pwdata <= wdata;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clock);
		penable <= 1'b1;
		@(negedge clock);
		rdata = prdata;
		err = pslverr;
		if (pready !== 1'b1) begin
			$display("pready_o was not high in an access cycle at t=%0t", $time);
			abortRun();
		end
		@(posedge clock);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic loadGpr(input regAddrT n, input gprT v);
		apbDataT rd;
		logic err;
		apbXfer(ADDR_W'(ADDR_GPR_BASE + 8 * int'(n)), 1'b1, v[32:63], rd, err); // Stage low
		apbXfer(ADDR_W'(ADDR_GPR_BASE + 8 * int'(n) + 4), 1'b1, v[0:31], rd, err); // Commit
		gprM[n] = v;
	endtask

	task automatic readGpr(input regAddrT n, output gprT v);
		apbDataT lo;
		apbDataT hi;
		logic err;
		apbXfer(ADDR_W'(ADDR_GPR_BASE + 8 * int'(n)), 1'b0, '0, lo, err);
		apbXfer(ADDR_W'(ADDR_GPR_BASE + 8 * int'(n) + 4), 1'b0, '0, hi, err);
		v = {hi, lo};
	endtask

	task automatic checkCrCa();
		apbDataT rd;
		logic err;
		apbXfer(ADDR_W'(ADDR_CR), 1'b0, '0, rd, err);
		checkCr("cr", rd, crM);
		apbXfer(ADDR_W'(ADDR_XER), 1'b0, '0, rd, err);
		checkBit("ca", rd[0], caM);
	endtask

	task automatic checkState(input regAddrT n);
		gprT v;
		readGpr(n, v);
		checkGpr($sformatf("gpr%0d", n), v, gprM[n]);
		checkCrCa();
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	task automatic modelExec(input instrT ins);
		logic [5:0] opc;
		logic [4:0] f1;
		logic [4:0] f2;
		logic [15:0] imm;
		logic [63:0] si;
		logic [63:0] ui;
		logic [63:0] a;
		logic [63:0] x;
		logic [63:0] res;
		logic [64:0] wide;
		logic [31:0] crL;
		logic lt;
		logic gt;
		logic eq;
		logic writes;
		logic rec;
		logic [4:0] dst;
		int fld;
		opc = ins[0:5];
		f1 = ins[6:10];
		f2 = ins[11:15];
		imm = ins[16:31];
		si = {{48{imm[15]}}, imm};
		ui = {48'b0, imm};
		a = gprM[f2];
		res = '0;
		writes = 1'b1;
		rec = 1'b0;
		dst = f1;
		crL = crM;
		fld = int'(f1[4:2]); // BF
		case (opc)
			OPC_ADDI: res = ((f2 == 5'd0) ? 64'd0 : a) + si;
			OPC_ADDIS: res = ((f2 == 5'd0) ? 64'd0 : a) + (si << 16);
			OPC_ADDIC, OPC_ADDICRC: begin
				wide = {1'b0, a} + {1'b0, si};
				res = wide[63:0];
				caM = wide[64];
				rec = (opc == OPC_ADDICRC);
			end
			OPC_SUBFIC: begin
				wide = {1'b0, ~a} + {1'b0, si} + 65'd1; // Carry means no borrow
				res = wide[63:0];
				caM = wide[64];
			end
			OPC_MULLI: res = a * si; // Low half same for signed
			OPC_ORI, OPC_ORIS, OPC_XORI, OPC_XORIS, OPC_ANDI, OPC_ANDIS: begin
				a = gprM[f1]; // RS in the first field
				dst = f2;
				case (opc)
					OPC_ORI: res = a | ui;
					OPC_ORIS: res = a | (ui << 16);
					OPC_XORI: res = a ^ ui;
					OPC_XORIS: res = a ^ (ui << 16);
					OPC_ANDI: res = a & ui;
					default: res = a & (ui << 16);
				endcase
				rec = (opc == OPC_ANDI) || (opc == OPC_ANDIS);
			end
			OPC_CMPI: begin
				writes = 1'b0;
				x = f1[0] ? a : {{32{a[31]}}, a[31:0]};
				lt = $signed(x) < $signed(si);
				gt = $signed(x) > $signed(si);
				eq = x == si;
				crL[31 - 4 * fld -: 4] = {lt, gt, eq, 1'b0};
			end
			OPC_CMPLI: begin
				writes = 1'b0;
				x = f1[0] ? a : {32'b0, a[31:0]};
				lt = x < ui;
				gt = x > ui;
				eq = x == ui;
				crL[31 - 4 * fld -: 4] = {lt, gt, eq, 1'b0};
			end
			default: writes = 1'b0; // Other unit, no change
		endcase
		if (rec) begin
			crL[31:28] = {res[63], !res[63] && (res != 64'd0), res == 64'd0, 1'b0};
		end
		crM = crL;
		if (writes) begin
			gprM[dst] = res;
		end
	endtask

	function automatic regAddrT checkedReg(input instrT ins);
		logic [5:0] opc;
		opc = ins[0:5];
		if (opc >= OPC_ORI && opc <= OPC_ANDIS) begin
			return ins[11:15]; // Logical target is RA
		end
		if (opc == OPC_CMPI || opc == OPC_CMPLI) begin
			return ins[11:15]; // Source must stay unchanged
		end
		return ins[6:10];
	endfunction

	task automatic issueAndCheck(input instrT ins);
		apbDataT rd;
		logic err;
		apbXfer(ADDR_W'(ADDR_INSTR), 1'b1, ins, rd, err);
		checkBit("pslverr_o", err, 1'b0);
		modelExec(ins);
		checkState(checkedReg(ins));
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	task automatic testAddImm();
		loadGpr(5'd3, 64'h0000_0001_FFFF_FFF0);
		loadGpr(5'd0, 64'h0000_0000_0000_1234); // Ignored by addi with RA=0
		issueAndCheck(dForm(OPC_ADDI, 5'd5, 5'd3, 16'h0020)); // Ripples into high word
		issueAndCheck(dForm(OPC_ADDI, 5'd6, 5'd3, 16'hFFFB)); // SI = -5
		issueAndCheck(dForm(OPC_ADDI, 5'd7, 5'd0, 16'h7FFF));
		issueAndCheck(dForm(OPC_ADDIS, 5'd8, 5'd3, 16'h8001)); // Negative shifted SI
		issueAndCheck(dForm(OPC_ADDIS, 5'd9, 5'd0, 16'h1234));
	endtask

	task automatic testCarry();
		loadGpr(5'd4, 64'hFFFF_FFFF_FFFF_FFFF);
		loadGpr(5'd12, 64'd5);
		loadGpr(5'd17, 64'hFFFF_FFFF_FFFF_FFF9); // -7
		issueAndCheck(dForm(OPC_ADDIC, 5'd10, 5'd4, 16'h0001)); // Wraps, CA=1
		issueAndCheck(dForm(OPC_ADDIC, 5'd11, 5'd12, 16'h0003)); // CA=0
		issueAndCheck(dForm(OPC_ADDIC, 5'd11, 5'd4, 16'hFFFE));
		issueAndCheck(dForm(OPC_ADDICRC, 5'd14, 5'd4, 16'h0001)); // CR0 EQ
		issueAndCheck(dForm(OPC_ADDICRC, 5'd14, 5'd12, 16'hFFF6)); // CR0 LT, no carry
		issueAndCheck(dForm(OPC_ADDICRC, 5'd14, 5'd12, 16'h0010)); // CR0 GT
		issueAndCheck(dForm(OPC_SUBFIC, 5'd15, 5'd12, 16'h0005)); // Zero, CA=1
		issueAndCheck(dForm(OPC_SUBFIC, 5'd15, 5'd12, 16'h0003)); // Borrow, CA=0
		issueAndCheck(dForm(OPC_MULLI, 5'd16, 5'd4, 16'hFFFD)); // -1 * -3
		issueAndCheck(dForm(OPC_MULLI, 5'd16, 5'd17, 16'h0064));
	endtask

	task automatic testLogical();
		loadGpr(5'd20, 64'hF0F0_1234_5678_9ABC);
		issueAndCheck(dForm(OPC_ORI, 5'd20, 5'd21, 16'h00FF)); // RS=20, RA=21
		issueAndCheck(dForm(OPC_ORIS, 5'd20, 5'd22, 16'hA5A5));
		issueAndCheck(dForm(OPC_XORI, 5'd20, 5'd23, 16'hFFFF));
		issueAndCheck(dForm(OPC_XORIS, 5'd20, 5'd24, 16'h8001));
		issueAndCheck(dForm(OPC_ANDI, 5'd20, 5'd25, 16'hFF00)); // CR0 GT
		issueAndCheck(dForm(OPC_ANDI, 5'd20, 5'd25, 16'h0001)); // CR0 EQ
		issueAndCheck(dForm(OPC_ANDIS, 5'd20, 5'd26, 16'h4000));
	endtask

	task automatic testCompare();
		loadGpr(5'd1, 64'hFFFF_FFFF_FFFF_FFFE); // -2, or huge unsigned
		loadGpr(5'd2, 64'h0000_0001_8000_0000); // Low word negative
		issueAndCheck(dForm(OPC_CMPI, cmpField(3'd2, 1'b1), 5'd1, 16'h0005)); // LT
		issueAndCheck(dForm(OPC_CMPLI, cmpField(3'd3, 1'b1), 5'd1, 16'h0005)); // GT
		issueAndCheck(dForm(OPC_CMPI, cmpField(3'd5, 1'b0), 5'd2, 16'h0000));
		issueAndCheck(dForm(OPC_CMPLI, cmpField(3'd6, 1'b0), 5'd2, 16'h8000));
		issueAndCheck(dForm(OPC_CMPI, cmpField(3'd7, 1'b1), 5'd2, 16'h0000));
		issueAndCheck(dForm(OPC_CMPI, cmpField(3'd1, 1'b1), 5'd1, 16'hFFFE)); // EQ
		issueAndCheck(dForm(OPC_CMPLI, cmpField(3'd4, 1'b0), 5'd1, 16'hFFFE));
	endtask

	task automatic testReject();
		logic [5:0] badOpc [4] = '{6'd32, 6'd31, 6'd0, 6'd58};
		apbDataT rd;
		logic err;
		gprT v;
		for (int i = 0; i < 4; i++) begin
			apbXfer(ADDR_W'(ADDR_INSTR), 1'b1, dForm(badOpc[i], 5'd5, 5'd3, 16'h7FFF), rd, err);
			checkBit("pslverr_o", err, 1'b1);
		end
		apbXfer(ADDR_W'(ADDR_CR), 1'b1, 32'hFFFF_FFFF, rd, err); // Read only
		apbXfer(ADDR_W'(ADDR_XER), 1'b1, 32'hFFFF_FFFF, rd, err);
		for (int n = 0; n < 32; n++) begin
			readGpr(5'(n), v);
			checkGpr($sformatf("gpr%0d", n), v, gprM[n]);
		end
		checkCrCa();
	endtask

	task automatic testRandom();
		logic [5:0] legal [14] = '{OPC_ADDI, OPC_ADDIS, OPC_ADDIC, OPC_ADDICRC, OPC_SUBFIC,
			OPC_MULLI, OPC_ANDI, OPC_ANDIS, OPC_ORI, OPC_ORIS, OPC_XORI, OPC_XORIS,
			OPC_CMPI, OPC_CMPLI};
		logic [31:0] r;
		logic [31:0] h;
		logic [3:0] idx;
		gprT v;
		for (int n = 0; n < 32; n++) begin
			nextRand(h);
			nextRand(r);
			v = {h, r};
			loadGpr(5'(n), v);
		end
		for (int k = 0; k < 40; k++) begin
			nextRand(r);
			idx = 4'(r % 32'd14);
			nextRand(h);
			issueAndCheck(dForm(legal[idx], r[8:4], r[13:9], h[15:0]));
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		paddr <= '0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		pwdata <= '0;
		for (int n = 0; n < 32; n++) begin
			gprM[n] = '0; // Matches reset state
		end
		crM = '0;
		caM = 1'b0;
		rndState = 32'd39908;
		@(posedge rstN);
		testAddImm();
		testCarry();
		testLogical();
		testCompare();
		testReject();
		testRandom();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
hw/fxPkg.sv
hw/fxDecode.sv
hw/fxRegFile.sv
hw/fxUnit.sv
hw/fxApbSlave.sv
hw/fxTop.sv
tb/fxClkGen.sv
tb/fxApb_chk.sv
tb/fxTb.sv

//--- Makefile
TOOL = verilator
FLAGS = --binary --timing --assert -j 0
TOP = fxTb
FILELIST = list.f
BUILD = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
